/* verilog/axis_stream_pkg.sv */
// stream width and source count defaults for the concat design
`default_nettype none

package axis_stream_pkg;

    // 64-bit data, one keep bit per byte lane
    parameter int DATA_W_DEF = 64;
    parameter int KEEP_W_DEF = 8;

    // sideband widths
    parameter int ID_W_DEF   = 4;
    parameter int USER_W_DEF = 2;

    // frames joined per output frame
    parameter int S_COUNT_DEF = 3;

endpackage

`default_nettype wire

/* verilog/concat_ctrl_pkg.sv */
// repack holding register state enum and source selector width helper
`default_nettype none

package concat_ctrl_pkg;

    // holding register occupancy
    typedef enum logic [1:0] {
        REP_EMPTY   = 2'd0,
        REP_PARTIAL = 2'd1,
        REP_TAIL    = 2'd2
    } repack_state_e;

    // bits to index count sources, never less than one
    function automatic int sel_w(input int count);
        int w;
        w = 1;
        while ((1 << w) < count) begin
            w = w + 1;
        end
        return w;
    endfunction

endpackage

`default_nettype wire

/* verilog/axis_concat_select.sv */
// source sequencing, per-source ready generation and input beat multiplexer
`timescale 1ns/10ps
`default_nettype none

module axis_concat_select #(
    parameter int S_COUNT,
    parameter int DATA_W,
    parameter int KEEP_W,
    parameter int ID_W,
    parameter int USER_W
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic [S_COUNT*DATA_W-1:0]   s_tdata,
    input  wire logic [S_COUNT*KEEP_W-1:0]   s_tkeep,
    input  wire logic [S_COUNT-1:0]          s_tvalid,
    input  wire logic [S_COUNT-1:0]          s_tlast,
    input  wire logic [S_COUNT*ID_W-1:0]     s_tid,
    input  wire logic [S_COUNT*USER_W-1:0]   s_tuser,
    output logic      [S_COUNT-1:0]          s_tready,
    input  wire logic                        ready_early,
    input  wire logic                        space_ok,
    output logic      [DATA_W-1:0]           cur_tdata,
    output logic      [KEEP_W-1:0]           cur_tkeep,
    output logic                             cur_tlast,
    output logic      [ID_W-1:0]             cur_tid,
    output logic      [USER_W-1:0]           cur_tuser,
    output logic                             cur_take,
    output logic                             grp_end
);

    localparam int SEL_W = concat_ctrl_pkg::sel_w(S_COUNT);

    logic [SEL_W-1:0]   sel_reg;
    logic [SEL_W-1:0]   sel_next;
    logic [S_COUNT-1:0] ready_reg;
    logic [S_COUNT-1:0] ready_next;
    logic               last_src;

    assign s_tready = ready_reg;

    // beat of the selected source
    assign cur_tdata = s_tdata[sel_reg*DATA_W +: DATA_W];
    assign cur_tkeep = s_tkeep[sel_reg*KEEP_W +: KEEP_W];
    assign cur_tlast = s_tlast[sel_reg];
    assign cur_tid   = s_tid[sel_reg*ID_W +: ID_W];
    assign cur_tuser = s_tuser[sel_reg*USER_W +: USER_W];
    assign cur_take  = s_tvalid[sel_reg] && ready_reg[sel_reg];

    assign last_src = sel_reg == SEL_W'(S_COUNT - 1);
    assign grp_end  = cur_take && cur_tlast && last_src;

    always_comb begin
        sel_next   = sel_reg;
        ready_next = '0;
        // step to the next source after each frame
        if (cur_take && cur_tlast) begin
            sel_next = last_src ? '0 : sel_reg + 1'b1;
        end
        ready_next[sel_next] = ready_early && space_ok;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg   <= '0;
            ready_reg <= '0;
        end else begin
            sel_reg   <= sel_next;
            ready_reg <= ready_next;
        end
    end

endmodule

`default_nettype wire

/* verilog/axis_concat_repack.sv */
// byte offset repacking of accepted beats into dense output words
`timescale 1ns/10ps
`default_nettype none

module axis_concat_repack #(
    parameter int DATA_W,
    parameter int KEEP_W,
    parameter int ID_W,
    parameter int USER_W
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic [DATA_W-1:0]   cur_tdata,
    input  wire logic [KEEP_W-1:0]   cur_tkeep,
    input  wire logic                cur_tlast,
    input  wire logic [ID_W-1:0]     cur_tid,
    input  wire logic [USER_W-1:0]   cur_tuser,
    input  wire logic                cur_take,
    input  wire logic                grp_end,
    input  wire logic                ready_reg,
    output logic                     space_ok,
    output logic      [DATA_W-1:0]   int_tdata,
    output logic      [KEEP_W-1:0]   int_tkeep,
    output logic                     int_tvalid,
    output logic                     int_tlast,
    output logic      [ID_W-1:0]     int_tid,
    output logic      [USER_W-1:0]   int_tuser
);

    localparam int BYTE_W = DATA_W / KEEP_W;
    localparam int OFF_W  = $clog2(KEEP_W);

    logic [2*DATA_W-1:0] data_reg;
    logic [2*DATA_W-1:0] data_next;
    logic [2*KEEP_W-1:0] keep_reg;
    logic [2*KEEP_W-1:0] keep_next;
    logic [1:0]          last_reg;
    logic [1:0]          last_next;
    logic [ID_W-1:0]     id_reg;
    logic [ID_W-1:0]     id_next;
    logic [USER_W-1:0]   user_reg;
    logic [USER_W-1:0]   user_next;
    logic [OFF_W-1:0]    off_reg;
    logic [OFF_W-1:0]    off_next;
    logic [OFF_W:0]      byte_cnt;

    concat_ctrl_pkg::repack_state_e state_reg;
    concat_ctrl_pkg::repack_state_e state_next;

    // keep is contiguous from lane 0
    always_comb begin
        byte_cnt = '0;
        for (int k = 0; k < KEEP_W; k++) begin
            if (cur_tkeep[k]) begin
                byte_cnt = (OFF_W + 1)'(k + 1);
            end
        end
    end

    always_comb begin
        data_next = data_reg;
        keep_next = keep_reg;
        last_next = last_reg;
        id_next   = id_reg;
        user_next = user_reg;
        off_next  = off_reg;
        space_ok  = state_reg != concat_ctrl_pkg::REP_TAIL || ready_reg;

        int_tdata  = data_reg[DATA_W-1:0];
        int_tkeep  = keep_reg[KEEP_W-1:0];
        int_tlast  = last_reg[0];
        int_tid    = id_reg;
        int_tuser  = user_reg;
        int_tvalid = 1'b0;

        // low word leaves once full or closing a group
        if (ready_reg && (keep_reg[KEEP_W-1] || last_reg[0])) begin
            data_next[DATA_W-1:0] = data_reg[2*DATA_W-1:DATA_W];
            keep_next  = {{KEEP_W{1'b0}}, keep_reg[2*KEEP_W-1:KEEP_W]};
            last_next  = {1'b0, last_reg[1]};
            int_tvalid = 1'b1;
        end

        if (cur_take) begin
            // place beat at the fill point
            data_next[off_reg*BYTE_W +: DATA_W] = cur_tdata;
            keep_next[off_reg +: KEEP_W] = cur_tkeep;
            id_next   = cur_tid;
            user_next = cur_tuser;
            off_next  = off_reg + OFF_W'(byte_cnt);
            if (grp_end) begin
                off_next = '0;
                if (keep_next[2*KEEP_W-1:KEEP_W] != '0) begin
                    // tail in upper word so hold off new input
                    last_next[1] = 1'b1;
                    space_ok     = 1'b0;
                end else begin
                    last_next[0] = 1'b1;
                end
            end
        end

        if (last_next[1]) begin
            state_next = concat_ctrl_pkg::REP_TAIL;
        end else if (keep_next != '0) begin
            state_next = concat_ctrl_pkg::REP_PARTIAL;
        end else begin
            state_next = concat_ctrl_pkg::REP_EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        data_reg <= data_next;
        id_reg   <= id_next;
        user_reg <= user_next;
        if (rst) begin
            keep_reg  <= '0;
            last_reg  <= '0;
            off_reg   <= '0;
            state_reg <= concat_ctrl_pkg::REP_EMPTY;
        end else begin
            keep_reg  <= keep_next;
            last_reg  <= last_next;
            off_reg   <= off_next;
            state_reg <= state_next;
        end
    end

endmodule

`default_nettype wire

/* verilog/axis_skid_reg.sv */
// two-entry output register slice with early ready forecast
`timescale 1ns/10ps
`default_nettype none

module axis_skid_reg #(
    parameter int DATA_W,
    parameter int KEEP_W,
    parameter int ID_W,
    parameter int USER_W
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic [DATA_W-1:0]   int_tdata,
    input  wire logic [KEEP_W-1:0]   int_tkeep,
    input  wire logic                int_tvalid,
    input  wire logic                int_tlast,
    input  wire logic [ID_W-1:0]     int_tid,
    input  wire logic [USER_W-1:0]   int_tuser,
    output logic                     ready_early,
    output logic                     ready_reg,
    output logic      [DATA_W-1:0]   m_tdata,
    output logic      [KEEP_W-1:0]   m_tkeep,
    output logic                     m_tvalid,
    output logic                     m_tlast,
    output logic      [ID_W-1:0]     m_tid,
    output logic      [USER_W-1:0]   m_tuser,
    input  wire logic                m_tready
);

    logic [DATA_W-1:0] tmp_data;
    logic [KEEP_W-1:0] tmp_keep;
    logic              tmp_last;
    logic [ID_W-1:0]   tmp_id;
    logic [USER_W-1:0] tmp_user;
    logic              tmp_valid;
    logic              tmp_valid_next;
    logic              out_valid_next;
    logic              int_to_out;
    logic              int_to_tmp;
    logic              tmp_to_out;

    // can take a word next cycle unless temp would fill
    assign ready_early = m_tready || (!tmp_valid && (!m_tvalid || !int_tvalid));

    always_comb begin
        out_valid_next = m_tvalid;
        tmp_valid_next = tmp_valid;
        int_to_out     = 1'b0;
        int_to_tmp     = 1'b0;
        tmp_to_out     = 1'b0;
        if (ready_reg) begin
            if (m_tready || !m_tvalid) begin
                out_valid_next = int_tvalid;
                int_to_out     = 1'b1;
            end else begin
                tmp_valid_next = int_tvalid;
                int_to_tmp     = 1'b1;
            end
        end else if (m_tready) begin
            // drain temp into the freed output slot
            out_valid_next = tmp_valid;
            tmp_valid_next = 1'b0;
            tmp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (int_to_out) begin
            m_tdata <= int_tdata;
            m_tkeep <= int_tkeep;
            m_tlast <= int_tlast;
            m_tid   <= int_tid;
            m_tuser <= int_tuser;
        end else if (tmp_to_out) begin
            m_tdata <= tmp_data;
            m_tkeep <= tmp_keep;
            m_tlast <= tmp_last;
            m_tid   <= tmp_id;
            m_tuser <= tmp_user;
        end
        if (int_to_tmp) begin
            tmp_data <= int_tdata;
            tmp_keep <= int_tkeep;
            tmp_last <= int_tlast;
            tmp_id   <= int_tid;
            tmp_user <= int_tuser;
        end
        if (rst) begin
            m_tvalid  <= 1'b0;
            tmp_valid <= 1'b0;
            ready_reg <= 1'b0;
        end else begin
            m_tvalid  <= out_valid_next;
            tmp_valid <= tmp_valid_next;
            ready_reg <= ready_early;
        end
    end

endmodule

`default_nettype wire

/* verilog/axis_concat.sv */
// frame concatenator top with source select, repack stage and output skid register
`timescale 1ns/10ps
`default_nettype none

module axis_concat #(
    parameter int S_COUNT = axis_stream_pkg::S_COUNT_DEF,
    parameter int DATA_W  = axis_stream_pkg::DATA_W_DEF,
    parameter int KEEP_W  = axis_stream_pkg::KEEP_W_DEF,
    parameter int ID_W    = axis_stream_pkg::ID_W_DEF,
    parameter int USER_W  = axis_stream_pkg::USER_W_DEF
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic [S_COUNT*DATA_W-1:0]   s_tdata,
    input  wire logic [S_COUNT*KEEP_W-1:0]   s_tkeep,
    input  wire logic [S_COUNT-1:0]          s_tvalid,
    output logic      [S_COUNT-1:0]          s_tready,
    input  wire logic [S_COUNT-1:0]          s_tlast,
    input  wire logic [S_COUNT*ID_W-1:0]     s_tid,
    input  wire logic [S_COUNT*USER_W-1:0]   s_tuser,
    output logic      [DATA_W-1:0]           m_tdata,
    output logic      [KEEP_W-1:0]           m_tkeep,
    output logic                             m_tvalid,
    input  wire logic                        m_tready,
    output logic                             m_tlast,
    output logic      [ID_W-1:0]             m_tid,
    output logic      [USER_W-1:0]           m_tuser
);

    // at least two sources
    if (S_COUNT < 2) begin : g_bad_count
        $fatal(1, "axis_concat needs S_COUNT of 2 or more");
    end
    if (DATA_W != KEEP_W * 8) begin : g_bad_width
        $fatal(1, "axis_concat needs one keep bit per data byte");
    end

    logic [DATA_W-1:0] cur_tdata;
    logic [KEEP_W-1:0] cur_tkeep;
    logic              cur_tlast;
    logic [ID_W-1:0]   cur_tid;
    logic [USER_W-1:0] cur_tuser;
    logic              cur_take;
    logic              grp_end;
    logic              space_ok;
    logic [DATA_W-1:0] int_tdata;
    logic [KEEP_W-1:0] int_tkeep;
    logic              int_tvalid;
    logic              int_tlast;
    logic [ID_W-1:0]   int_tid;
    logic [USER_W-1:0] int_tuser;
    logic              ready_early;
    logic              ready_reg;

    axis_concat_select #(
        .S_COUNT(S_COUNT), .DATA_W(DATA_W), .KEEP_W(KEEP_W), .ID_W(ID_W), .USER_W(USER_W)
    ) u_select (
        .clk(clk), .rst(rst),
        .s_tdata(s_tdata), .s_tkeep(s_tkeep), .s_tvalid(s_tvalid), .s_tlast(s_tlast),
        .s_tid(s_tid), .s_tuser(s_tuser), .s_tready(s_tready),
        .ready_early(ready_early), .space_ok(space_ok),
        .cur_tdata(cur_tdata), .cur_tkeep(cur_tkeep), .cur_tlast(cur_tlast),
        .cur_tid(cur_tid), .cur_tuser(cur_tuser), .cur_take(cur_take), .grp_end(grp_end)
    );

    axis_concat_repack #(
        .DATA_W(DATA_W), .KEEP_W(KEEP_W), .ID_W(ID_W), .USER_W(USER_W)
    ) u_repack (
        .clk(clk), .rst(rst),
        .cur_tdata(cur_tdata), .cur_tkeep(cur_tkeep), .cur_tlast(cur_tlast),
        .cur_tid(cur_tid), .cur_tuser(cur_tuser), .cur_take(cur_take), .grp_end(grp_end),
        .ready_reg(ready_reg), .space_ok(space_ok),
        .int_tdata(int_tdata), .int_tkeep(int_tkeep), .int_tvalid(int_tvalid),
        .int_tlast(int_tlast), .int_tid(int_tid), .int_tuser(int_tuser)
    );

    axis_skid_reg #(
        .DATA_W(DATA_W), .KEEP_W(KEEP_W), .ID_W(ID_W), .USER_W(USER_W)
    ) u_skid (
        .clk(clk), .rst(rst),
        .int_tdata(int_tdata), .int_tkeep(int_tkeep), .int_tvalid(int_tvalid),
        .int_tlast(int_tlast), .int_tid(int_tid), .int_tuser(int_tuser),
        .ready_early(ready_early), .ready_reg(ready_reg),
        .m_tdata(m_tdata), .m_tkeep(m_tkeep), .m_tvalid(m_tvalid), .m_tlast(m_tlast),
        .m_tid(m_tid), .m_tuser(m_tuser), .m_tready(m_tready)
    );

endmodule

`default_nettype wire

/* dv/axis_concat_checker.sv */
// output watcher comparing concatenated words with the expected byte queue
`timescale 1ns/10ps
`default_nettype none

module axis_concat_checker #(
    parameter int S_COUNT,
    parameter int DATA_W,
    parameter int KEEP_W,
    parameter int ID_W,
    parameter int USER_W
) (
    input wire logic                  clk,
    input wire logic                  rst,
    input wire logic [S_COUNT-1:0]    s_tvalid,
    input wire logic [S_COUNT-1:0]    s_tready,
    input wire logic [S_COUNT-1:0]    s_tlast,
    input wire logic [DATA_W-1:0]     m_tdata,
    input wire logic [KEEP_W-1:0]     m_tkeep,
    input wire logic                  m_tvalid,
    input wire logic                  m_tready,
    input wire logic                  m_tlast,
    input wire logic [ID_W-1:0]       m_tid,
    input wire logic [USER_W-1:0]     m_tuser,
    input wire concat_ctrl_pkg::repack_state_e rep_state
);

    // entry is {group end, id, user, byte}
    localparam int E_W = 9 + ID_W + USER_W;

    logic [E_W-1:0]    exp_q[$];
    int                err_cnt = 0;
    int                cur_src = 0;
    logic              rst_d = 1'b1;
    logic              stall_d = 1'b0;
    logic [DATA_W-1:0] data_d;
    logic [KEEP_W-1:0] keep_d;
    logic              last_d;

    task automatic add_byte(input logic [E_W-1:0] e);
        exp_q.push_back(e);
    endtask

    function automatic int pending();
        return exp_q.size();
    endfunction

    task automatic check_word();
        logic [E_W-1:0] e;
        logic [E_W-1:0] last_e;
        logic           gap;
        int             got;
        gap = 1'b0;
        got = 0;
        last_e = '0;
        for (int k = 0; k < KEEP_W; k++) begin
            if (!m_tkeep[k]) begin
                gap = 1'b1;
            end else if (gap) begin
                $display("%0t: m_tkeep %b is not contiguous from lane 0", $time, m_tkeep);
                err_cnt++;
            end else if (exp_q.size() == 0) begin
                $display("%0t: output byte in lane %0d with no byte left to expect", $time, k);
                err_cnt++;
            end else begin
                e = exp_q.pop_front();
                if (got > 0 && last_e[E_W-1]) begin
                    $display("%0t: group ended inside a word, lane %0d follows it", $time, k);
                    err_cnt++;
                end
                if (m_tdata[k*8 +: 8] != e[7:0]) begin
                    $display("ERR %0t m_tdata lane %0d expected %h got %h",
                             $time, k, e[7:0], m_tdata[k*8 +: 8]);
                    err_cnt++;
                end
                last_e = e;
                got++;
            end
        end
        if (got == 0) begin
            $display("%0t: word with no bytes, repack state %s", $time, rep_state.name());
            err_cnt++;
        end else begin
            if (m_tlast != last_e[E_W-1]) begin
                $display("ERR %0t m_tlast expected %b got %b", $time, last_e[E_W-1], m_tlast);
                err_cnt++;
            end
            if (!m_tlast && m_tkeep != '1) begin
                $display("ERR %0t m_tkeep expected %h got %h", $time, {KEEP_W{1'b1}}, m_tkeep);
                err_cnt++;
            end
            if (m_tid != last_e[8+USER_W +: ID_W]) begin
                $display("ERR %0t m_tid expected %h got %h",
                         $time, last_e[8+USER_W +: ID_W], m_tid);
                err_cnt++;
            end
            if (m_tuser != last_e[8 +: USER_W]) begin
                $display("ERR %0t m_tuser expected %h got %h",
                         $time, last_e[8 +: USER_W], m_tuser);
                err_cnt++;
            end
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rst || rst_d) begin
            if (s_tready !== '0 || m_tvalid !== 1'b0) begin
                $display("%0t: ready or m_tvalid high during or right after reset", $time);
                err_cnt++;
            end
            cur_src = 0;
        end else begin
            for (int s = 0; s < S_COUNT; s++) begin
                if (s_tvalid[s] && s_tready[s]) begin
                    if (s != cur_src) begin
                        $display("%0t: beat taken on source %0d while source %0d is current",
                                 $time, s, cur_src);
                        err_cnt++;
                    end else if (s_tlast[s]) begin
                        cur_src = (cur_src == S_COUNT - 1) ? 0 : cur_src + 1;
                    end
                end
            end
            if (stall_d && (!m_tvalid || m_tdata != data_d || m_tkeep != keep_d
                            || m_tlast != last_d)) begin
                $display("%0t: output word changed while stalled", $time);
                err_cnt++;
            end
            if (m_tvalid && m_tready) begin
                check_word();
            end
        end
        rst_d   = rst;
        stall_d = m_tvalid && !m_tready;
        data_d  = m_tdata;
        keep_d  = m_tkeep;
        last_d  = m_tlast;
    end

endmodule

`default_nettype wire

/* dv/tb_axis_concat.sv */
// testbench with clock, reset, random frame drivers, expected byte model and timeout
`timescale 1ns/10ps
`default_nettype none

module tb_axis_concat;

    localparam int S_COUNT = axis_stream_pkg::S_COUNT_DEF;
    localparam int DATA_W  = axis_stream_pkg::DATA_W_DEF;
    localparam int KEEP_W  = axis_stream_pkg::KEEP_W_DEF;
    localparam int ID_W    = axis_stream_pkg::ID_W_DEF;
    localparam int USER_W  = axis_stream_pkg::USER_W_DEF;
    localparam int E_W     = 9 + ID_W + USER_W;

    logic                      clk = 1'b0;
    logic                      rst;
    logic [S_COUNT*DATA_W-1:0] s_tdata;
    logic [S_COUNT*KEEP_W-1:0] s_tkeep;
    logic [S_COUNT-1:0]        s_tvalid;
    logic [S_COUNT-1:0]        s_tready;
    logic [S_COUNT-1:0]        s_tlast;
    logic [S_COUNT*ID_W-1:0]   s_tid;
    logic [S_COUNT*USER_W-1:0] s_tuser;
    logic [DATA_W-1:0]         m_tdata;
    logic [KEEP_W-1:0]         m_tkeep;
    logic                      m_tvalid;
    logic                      m_tready;
    logic                      m_tlast;
    logic [ID_W-1:0]           m_tid;
    logic [USER_W-1:0]         m_tuser;

    // per source entry is {frame end, id, user, byte}
    logic [E_W-1:0] src_q[S_COUNT][$];
    logic           busy_src[S_COUNT];
    int             beat_n[S_COUNT];
    int             cycles = 0;
    int             limit = 1000;
    int             passed = 0;
    int             failed = 0;

    always #4 clk = ~clk;

    axis_concat #(
        .S_COUNT(S_COUNT), .DATA_W(DATA_W), .KEEP_W(KEEP_W), .ID_W(ID_W), .USER_W(USER_W)
    ) u_axis_concat (
        .clk(clk), .rst(rst),
        .s_tdata(s_tdata), .s_tkeep(s_tkeep), .s_tvalid(s_tvalid), .s_tready(s_tready),
        .s_tlast(s_tlast), .s_tid(s_tid), .s_tuser(s_tuser),
        .m_tdata(m_tdata), .m_tkeep(m_tkeep), .m_tvalid(m_tvalid), .m_tready(m_tready),
        .m_tlast(m_tlast), .m_tid(m_tid), .m_tuser(m_tuser)
    );

    axis_concat_checker #(
        .S_COUNT(S_COUNT), .DATA_W(DATA_W), .KEEP_W(KEEP_W), .ID_W(ID_W), .USER_W(USER_W)
    ) u_chk (
        .clk(clk), .rst(rst),
        .s_tvalid(s_tvalid), .s_tready(s_tready), .s_tlast(s_tlast),
        .m_tdata(m_tdata), .m_tkeep(m_tkeep), .m_tvalid(m_tvalid), .m_tready(m_tready),
        .m_tlast(m_tlast), .m_tid(m_tid), .m_tuser(m_tuser),
        .rep_state(u_axis_concat.u_repack.state_reg)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: output still incomplete after %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    // mode 1 makes one-byte frames, mode 2 makes group totals a word multiple
    task automatic build_groups(input int mode, input int groups, output int total);
        int                len;
        int                sum;
        logic [ID_W-1:0]   id;
        logic [USER_W-1:0] user;
        logic [7:0]        b;
        logic              fend;
        total = 0;
        for (int g = 0; g < groups; g++) begin
            sum = 0;
            for (int s = 0; s < S_COUNT; s++) begin
                len = (mode == 1) ? 1 : int'($urandom % 20) + 1;
                if (mode == 2 && s == S_COUNT - 1) begin
                    len = (KEEP_W - sum % KEEP_W) % KEEP_W;
                    if (len == 0) begin
                        len = KEEP_W;
                    end
                end
                sum  = sum + len;
                id   = ID_W'($urandom);
                user = USER_W'($urandom);
                for (int i = 0; i < len; i++) begin
                    b    = 8'($urandom);
                    fend = i == len - 1;
                    src_q[s].push_back({fend, id, user, b});
                    u_chk.add_byte({fend && s == S_COUNT - 1, id, user, b});
                    total++;
                end
            end
        end
    endtask

    function automatic logic busy();
        logic any;
        any = u_chk.pending() > 0;
        for (int s = 0; s < S_COUNT; s++) begin
            any = any || src_q[s].size() > 0 || busy_src[s];
        end
        return any;
    endfunction

    task automatic step_cycle(input logic bp);
        logic [S_COUNT-1:0] accept;
        logic [DATA_W-1:0]  data;
        logic [E_W-1:0]     e;
        logic               fend;
        int                 n;
        @(negedge clk);
        accept = s_tvalid & s_tready;
        @(posedge clk);
        for (int s = 0; s < S_COUNT; s++) begin
            if (accept[s]) begin
                repeat (beat_n[s]) void'(src_q[s].pop_front());
                busy_src[s] = 1'b0;
            end
            if (!busy_src[s] && src_q[s].size() > 0 && ($urandom % 4) != 0) begin
                n    = 0;
                fend = 1'b0;
                data = '0;
                while (n < KEEP_W && n < src_q[s].size() && !fend) begin
                    e = src_q[s][n];
                    data[n*8 +: 8] = e[7:0];
                    fend = e[E_W-1];
                    n++;
                end
                beat_n[s]   = n;
                busy_src[s] = 1'b1;
                s_tdata[s*DATA_W +: DATA_W] <= data;
                s_tkeep[s*KEEP_W +: KEEP_W] <= KEEP_W'((1 << n) - 1);
                s_tlast[s]                  <= fend;
                s_tid[s*ID_W +: ID_W]       <= e[8+USER_W +: ID_W];
                s_tuser[s*USER_W +: USER_W] <= e[8 +: USER_W];
                s_tvalid[s]                 <= 1'b1;
            end else if (!busy_src[s]) begin
                s_tvalid[s] <= 1'b0;
            end
        end
        m_tready <= bp ? 1'($urandom % 2) : 1'b1;
    endtask

    task automatic report(input string name, input int err_before);
        if (u_chk.err_cnt == err_before) begin
            passed++;
            $display("test %s: pass", name);
        end else begin
            failed++;
            $display("test %s: fail with %0d errors", name, u_chk.err_cnt - err_before);
        end
    endtask

    task automatic run_test(input string name, input int mode, input logic bp,
                            input int groups);
        int total;
        int err_before;
        err_before = u_chk.err_cnt;
        build_groups(mode, groups, total);
        limit = cycles + 40 * total + 200;
        while (busy()) begin
            step_cycle(bp);
        end
        report(name, err_before);
    endtask

    initial begin
        void'($urandom(32'h95ae6f6f));
        rst      = 1'b1;
        s_tdata  = '0;
        s_tkeep  = '0;
        s_tvalid = '0;
        s_tlast  = '0;
        s_tid    = '0;
        s_tuser  = '0;
        m_tready = 1'b1;
        for (int s = 0; s < S_COUNT; s++) begin
            busy_src[s] = 1'b0;
            beat_n[s]   = 0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        report("reset", 0);
        run_test("order_and_packing", 0, 1'b0, 8);
        run_test("back_pressure", 0, 1'b1, 10);
        run_test("one_byte_frames", 1, 1'b1, 6);
        run_test("word_multiple_groups", 2, 1'b1, 8);
        $display("tests passed %0d failed %0d", passed, failed);
        if (failed == 0 && u_chk.err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* axis_concat.f */
verilog/axis_stream_pkg.sv
verilog/concat_ctrl_pkg.sv
verilog/axis_concat_select.sv
verilog/axis_concat_repack.sv
verilog/axis_skid_reg.sv
verilog/axis_concat.sv
dv/axis_concat_checker.sv
dv/tb_axis_concat.sv

/* Makefile */
TOP = tb_axis_concat

.PHONY: sim clean

sim:
	verilator --binary --top-module $(TOP) -f axis_concat.f --Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep "Everything OK" > /dev/null

clean:
	rm -rf obj_dir
